// File: include/csr_addr.svh
`ifndef CSR_ADDR_SVH
`define CSR_ADDR_SVH

// machine trap setup and handling.
`define CSR_MSTATUS   12'h300
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342

// machine information registers, read only.
`define CSR_MVENDORID 12'hf11
`define CSR_MARCHID   12'hf12

// mstatus fields kept by this core.
`define MSTATUS_MIE_IDX  3
`define MSTATUS_MPIE_IDX 7

`endif

// File: source/exu_pkg.sv
package exu_pkg;

  // datapath word width.
  localparam int xlen = 32;

  // csr address field of the instruction.
  localparam int csr_addr_w = 12;

  // csr operation, low funct3 bits map onto it directly.
  typedef enum logic [1:0] {
    csr_op_none = 2'd0,
    csr_op_rw   = 2'd1, // replace.
    csr_op_rs   = 2'd2, // set bits.
    csr_op_rc   = 2'd3  // clear bits.
  } csr_op_t;

  // mcause codes.
  localparam logic [xlen-1:0] cause_ecall_m = 32'd11; // ecall from m-mode.

  // identity constants returned by mvendorid and marchid.
  localparam logic [xlen-1:0] mvendorid_val = 32'h5253_4356;
  localparam logic [xlen-1:0] marchid_val   = 32'h0000_002a;

endpackage

// File: source/csr_decode.sv
`timescale 1ns/1ps
`include "csr_addr.svh"

module csr_decode (
  input  logic [31:0]                        inst,
  output exu_pkg::csr_op_t                   op,
  output logic [exu_pkg::csr_addr_w-1:0]     csr_addr,
  output logic                               use_imm,
  output logic [4:0]                         zimm,
  output logic                               write_req,
  output logic                               ecall,
  output logic                               mret
);

  localparam logic [6:0]  opcode_system = 7'b1110011;
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [11:0] funct12;
  logic        is_system;
  logic        is_csr;
  logic        src_zero;
  logic        read_only;

  assign opcode  = inst[6:0];
  assign funct3  = inst[14:12];
  assign funct12 = inst[31:20];

  assign is_system = (opcode == opcode_system);
  assign is_csr    = is_system && (funct3[1:0] != 2'b00);

  assign csr_addr = inst[31:20];
  assign zimm     = inst[19:15]; // rs1 index or uimm, same field.
  assign use_imm  = funct3[2];

  // identity registers never take a write.
  assign read_only = (csr_addr == `CSR_MVENDORID) || (csr_addr == `CSR_MARCHID);
  assign src_zero  = (inst[19:15] == 5'd0);

  always_comb begin
    op = exu_pkg::csr_op_none;
    if (is_csr) begin
      case (funct3[1:0])
        2'b01:   op = exu_pkg::csr_op_rw;
        2'b10:   op = exu_pkg::csr_op_rs;
        2'b11:   op = exu_pkg::csr_op_rc;
        default: op = exu_pkg::csr_op_none;
      endcase
    end
  end

  // set and clear with x0 or a zero immediate are pure reads.
  always_comb begin
    write_req = 1'b0;
    if (is_csr && !read_only) begin
      if (op == exu_pkg::csr_op_rw)
        write_req = 1'b1;
      else
        write_req = !src_zero;
    end
  end

  assign ecall = is_system && (funct3 == 3'b000) && (funct12 == funct12_ecall);
  assign mret  = is_system && (funct3 == 3'b000) && (funct12 == funct12_mret);

endmodule

// File: source/csr_exec.sv
`timescale 1ns/1ps
`include "csr_addr.svh"

module csr_exec #(
  parameter int XLEN = exu_pkg::xlen
) (
  input  logic                               valid,
  input  exu_pkg::csr_op_t                   op,
  input  logic                               use_imm,
  input  logic [4:0]                         zimm,
  input  logic                               write_req,
  input  logic                               ecall,
  input  logic                               mret,
  input  logic [XLEN-1:0]                    rs1_data,
  input  logic [XLEN-1:0]                    pc,
  input  logic [exu_pkg::csr_addr_w-1:0]     csr_addr,
  input  logic [XLEN-1:0]                    rdata,
  input  logic [XLEN-1:0]                    mtvec,
  input  logic [XLEN-1:0]                    mepc,
  output logic                               wen,
  output logic [exu_pkg::csr_addr_w-1:0]     waddr,
  output logic [exu_pkg::csr_addr_w-1:0]     waddr2,
  output logic [XLEN-1:0]                    wdata,
  output logic [XLEN-1:0]                    wdata2,
  output logic                               trap_enter,
  output logic                               trap_return,
  output logic                               redirect,
  output logic [XLEN-1:0]                    redirect_pc
);

  // unmapped address, lands in the discard slot of the register file.
  localparam logic [exu_pkg::csr_addr_w-1:0] addr_idle = '0;

  logic [XLEN-1:0] operand;
  logic [XLEN-1:0] new_val;
  logic [XLEN-1:0] trap_vec;

  assign operand = use_imm ? {{(XLEN-5){1'b0}}, zimm} : rs1_data;

  always_comb begin
    case (op)
      exu_pkg::csr_op_rw: new_val = operand;
      exu_pkg::csr_op_rs: new_val = rdata | operand;
      exu_pkg::csr_op_rc: new_val = rdata & ~operand;
      default:            new_val = rdata;
    endcase
  end

  assign trap_enter  = valid && ecall;
  assign trap_return = valid && mret;

  // ecall takes both ports, mcause on port 1 and mepc on port 2.
  always_comb begin
    wen    = 1'b0;
    waddr  = csr_addr;
    wdata  = new_val;
    waddr2 = addr_idle;
    wdata2 = pc;
    if (trap_enter) begin
      wen    = 1'b1;
      waddr  = `CSR_MCAUSE;
      wdata  = XLEN'(exu_pkg::cause_ecall_m);
      waddr2 = `CSR_MEPC;
    end else if (valid && write_req) begin
      wen = 1'b1;
    end
  end

  assign trap_vec = {mtvec[XLEN-1:2], 2'b00}; // direct mode only.

  assign redirect = trap_enter || trap_return;

  always_comb begin
    if (trap_enter)
      redirect_pc = trap_vec;
    else if (trap_return)
      redirect_pc = mepc;
    else
      redirect_pc = '0;
  end

endmodule

// File: source/csr_regfile.sv
`timescale 1ns/1ps
`include "csr_addr.svh"

module csr_regfile #(
  parameter int              XLEN      = exu_pkg::xlen,
  parameter logic [XLEN-1:0] RESET_VAL = '0
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [exu_pkg::csr_addr_w-1:0]     raddr,
  input  logic                               wen,
  input  logic [exu_pkg::csr_addr_w-1:0]     waddr,
  input  logic [XLEN-1:0]                    wdata,
  input  logic [exu_pkg::csr_addr_w-1:0]     waddr2,
  input  logic [XLEN-1:0]                    wdata2,
  input  logic                               trap_enter,
  input  logic                               trap_return,
  output logic [XLEN-1:0]                    rdata,
  output logic [XLEN-1:0]                    mtvec,
  output logic [XLEN-1:0]                    mepc,
  output logic                               mie
);

  // storage slots, bit 2 marks the discard slot.
  localparam logic [2:0] slot_mstatus = 3'd0;
  localparam logic [2:0] slot_mcause  = 3'd1;
  localparam logic [2:0] slot_mepc    = 3'd2;
  localparam logic [2:0] slot_mtvec   = 3'd3;
  localparam logic [2:0] slot_none    = 3'd4;

  logic [XLEN-1:0] csr [4];
  logic [2:0]      wslot1;
  logic [2:0]      wslot2;

  function automatic logic [2:0] slot_of(input logic [exu_pkg::csr_addr_w-1:0] addr);
    logic [2:0] slot;
    case (addr)
      `CSR_MSTATUS: slot = slot_mstatus;
      `CSR_MCAUSE:  slot = slot_mcause;
      `CSR_MEPC:    slot = slot_mepc;
      `CSR_MTVEC:   slot = slot_mtvec;
      default:      slot = slot_none;
    endcase
    return slot;
  endfunction

  assign wslot1 = slot_of(waddr);
  assign wslot2 = slot_of(waddr2);

  always_comb begin
    case (raddr)
      `CSR_MVENDORID: rdata = XLEN'(exu_pkg::mvendorid_val);
      `CSR_MARCHID:   rdata = XLEN'(exu_pkg::marchid_val);
      `CSR_MSTATUS:   rdata = csr[slot_mstatus[1:0]];
      `CSR_MCAUSE:    rdata = csr[slot_mcause[1:0]];
      `CSR_MEPC:      rdata = csr[slot_mepc[1:0]];
      `CSR_MTVEC:     rdata = csr[slot_mtvec[1:0]];
      default:        rdata = '0; // unimplemented reads as zero.
    endcase
  end

  assign mtvec = csr[slot_mtvec[1:0]];
  assign mepc  = csr[slot_mepc[1:0]];
  assign mie   = csr[slot_mstatus[1:0]][`MSTATUS_MIE_IDX];

  // later assignments win: port 2 over port 1, stacking over both.
  always_ff @(posedge clk) begin
    if (rst) begin
      csr[slot_mstatus[1:0]] <= RESET_VAL;
      csr[slot_mcause[1:0]]  <= RESET_VAL;
      csr[slot_mepc[1:0]]    <= RESET_VAL;
      csr[slot_mtvec[1:0]]   <= RESET_VAL;
    end else begin
      if (wen) begin
        if (wslot1 != slot_none)
          csr[wslot1[1:0]] <= wdata;
        if (wslot2 != slot_none)
          csr[wslot2[1:0]] <= wdata2;
      end
      if (trap_enter) begin
        csr[slot_mstatus[1:0]][`MSTATUS_MPIE_IDX] <= csr[slot_mstatus[1:0]][`MSTATUS_MIE_IDX];
        csr[slot_mstatus[1:0]][`MSTATUS_MIE_IDX]  <= 1'b0;
      end else if (trap_return) begin
        csr[slot_mstatus[1:0]][`MSTATUS_MIE_IDX]  <= csr[slot_mstatus[1:0]][`MSTATUS_MPIE_IDX];
        csr[slot_mstatus[1:0]][`MSTATUS_MPIE_IDX] <= 1'b1;
      end
    end
  end

endmodule

// File: source/exu_csr_unit.sv
`timescale 1ns/1ps

module exu_csr_unit #(
  parameter int              XLEN      = exu_pkg::xlen,
  parameter logic [XLEN-1:0] RESET_VAL = '0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            valid,
  input  logic [31:0]     inst,
  input  logic [XLEN-1:0] pc,
  input  logic [XLEN-1:0] rs1_data,
  output logic [XLEN-1:0] rd_data,
  output logic            redirect,
  output logic [XLEN-1:0] redirect_pc,
  output logic [XLEN-1:0] mtvec,
  output logic [XLEN-1:0] mepc,
  output logic            mie
);

  exu_pkg::csr_op_t                   op;
  logic [exu_pkg::csr_addr_w-1:0]     csr_addr;
  logic                               use_imm;
  logic [4:0]                         zimm;
  logic                               write_req;
  logic                               ecall;
  logic                               mret;
  logic                               wen;
  logic [exu_pkg::csr_addr_w-1:0]     waddr;
  logic [exu_pkg::csr_addr_w-1:0]     waddr2;
  logic [XLEN-1:0]                    wdata;
  logic [XLEN-1:0]                    wdata2;
  logic                               trap_enter;
  logic                               trap_return;

  csr_decode u_decode (
    .inst      (inst),
    .op        (op),
    .csr_addr  (csr_addr),
    .use_imm   (use_imm),
    .zimm      (zimm),
    .write_req (write_req),
    .ecall     (ecall),
    .mret      (mret)
  );

  // rd_data is the old value, taken straight from the read port.
  csr_exec #(.XLEN(XLEN)) u_exec (
    .valid (valid), .op (op), .use_imm (use_imm), .zimm (zimm),
    .write_req (write_req), .ecall (ecall), .mret (mret),
    .rs1_data (rs1_data), .pc (pc), .csr_addr (csr_addr),
    .rdata (rd_data), .mtvec (mtvec), .mepc (mepc),
    .wen (wen), .waddr (waddr), .waddr2 (waddr2),
    .wdata (wdata), .wdata2 (wdata2),
    .trap_enter (trap_enter), .trap_return (trap_return),
    .redirect (redirect), .redirect_pc (redirect_pc)
  );

  csr_regfile #(.XLEN(XLEN), .RESET_VAL(RESET_VAL)) u_regfile (
    .clk (clk), .rst (rst), .raddr (csr_addr),
    .wen (wen), .waddr (waddr), .wdata (wdata),
    .waddr2 (waddr2), .wdata2 (wdata2),
    .trap_enter (trap_enter), .trap_return (trap_return),
    .rdata (rd_data), .mtvec (mtvec), .mepc (mepc), .mie (mie)
  );

endmodule

// File: tb/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD       = 4,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge.
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

// File: tb/exu_csr_sva.sv
`timescale 1ns/1ps
`include "csr_addr.svh"

module exu_csr_sva #(
  parameter int XLEN = exu_pkg::xlen
) (
  input logic            clk,
  input logic            rst,
  input logic            valid,
  input logic [31:0]     inst,
  input logic [XLEN-1:0] pc,
  input logic [XLEN-1:0] rs1_data,
  input logic [XLEN-1:0] rd_data,
  input logic            redirect,
  input logic [XLEN-1:0] redirect_pc,
  input logic [XLEN-1:0] mtvec,
  input logic [XLEN-1:0] mepc,
  input logic            mie
);

  int unsigned fail_count = 0; // polled by the testbench.

  logic [XLEN-1:0] sh_mstatus;
  logic [XLEN-1:0] sh_mcause;
  logic [XLEN-1:0] sh_mepc;
  logic [XLEN-1:0] sh_mtvec;
  logic [XLEN-1:0] ecall_pc;
  logic            stacked_mpie;
  logic [2:0]      f3;
  logic [11:0]     addr;
  logic [4:0]      src;
  logic            is_csr;
  logic            is_ecall;
  logic            is_mret;
  logic            writes;
  logic [XLEN-1:0] operand;
  logic [XLEN-1:0] old_val;
  logic [XLEN-1:0] new_val;

  assign f3       = inst[14:12];
  assign addr     = inst[31:20];
  assign src      = inst[19:15];
  assign is_csr   = valid && (inst[6:0] == 7'b1110011) && (f3[1:0] != 2'b00);
  assign is_ecall = valid && (inst == 32'h0000_0073);
  assign is_mret  = valid && (inst == 32'h3020_0073);
  assign operand  = f3[2] ? XLEN'(src) : rs1_data;
  assign writes   = is_csr && ((f3[1:0] == 2'b01) || (src != 5'd0)); // zero source only reads.

  always_comb begin
    case (addr)
      `CSR_MSTATUS:   old_val = sh_mstatus;
      `CSR_MCAUSE:    old_val = sh_mcause;
      `CSR_MEPC:      old_val = sh_mepc;
      `CSR_MTVEC:     old_val = sh_mtvec;
      `CSR_MVENDORID: old_val = XLEN'(exu_pkg::mvendorid_val);
      `CSR_MARCHID:   old_val = XLEN'(exu_pkg::marchid_val);
      default:        old_val = '0;
    endcase
  end

  always_comb begin
    case (f3[1:0])
      2'b01:   new_val = operand;
      2'b10:   new_val = old_val | operand;
      default: new_val = old_val & ~operand;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sh_mstatus   <= '0;
      sh_mcause    <= '0;
      sh_mepc      <= '0;
      sh_mtvec     <= '0;
      ecall_pc     <= '0;
      stacked_mpie <= 1'b0;
    end else if (is_ecall) begin
      sh_mcause                      <= XLEN'(11);
      sh_mepc                        <= pc;
      ecall_pc                       <= pc;
      sh_mstatus[`MSTATUS_MPIE_IDX]  <= sh_mstatus[`MSTATUS_MIE_IDX];
      sh_mstatus[`MSTATUS_MIE_IDX]   <= 1'b0;
    end else if (is_mret) begin
      stacked_mpie                   <= sh_mstatus[`MSTATUS_MPIE_IDX];
      sh_mstatus[`MSTATUS_MIE_IDX]   <= sh_mstatus[`MSTATUS_MPIE_IDX];
      sh_mstatus[`MSTATUS_MPIE_IDX]  <= 1'b1;
    end else if (writes) begin
      case (addr)
        `CSR_MSTATUS: sh_mstatus <= new_val;
        `CSR_MCAUSE:  sh_mcause  <= new_val;
        `CSR_MEPC:    sh_mepc    <= new_val;
        `CSR_MTVEC:   sh_mtvec   <= new_val;
        default:      ; // constants and unknown addresses hold nothing.
      endcase
    end
  end

  task count_failure();
    fail_count = fail_count + 1;
  endtask

  a_reset: assert property (@(posedge clk)
    rst |=> !redirect && !mie && (mtvec == '0) && (mepc == '0))
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t reset state redirect=%b mie=%b mtvec=%h mepc=%h expected 0",
             $time, $sampled(redirect), $sampled(mie), $sampled(mtvec), $sampled(mepc));
    end

  a_rd_data: assert property (@(posedge clk) disable iff (rst)
    is_csr |-> rd_data == old_val)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t rd_data got %h expected %h",
             $time, $sampled(rd_data), $sampled(old_val));
    end

  a_redirect: assert property (@(posedge clk) disable iff (rst)
    redirect == (is_ecall || is_mret))
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t redirect got %b expected %b",
             $time, $sampled(redirect), $sampled(is_ecall || is_mret));
    end

  // direct mode vector.
  a_trap_pc: assert property (@(posedge clk) disable iff (rst)
    is_ecall |-> redirect_pc == {sh_mtvec[XLEN-1:2], 2'b00})
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t redirect_pc got %h expected %h",
             $time, $sampled(redirect_pc), {$sampled(sh_mtvec[XLEN-1:2]), 2'b00});
    end

  a_return_pc: assert property (@(posedge clk) disable iff (rst)
    is_mret |-> redirect_pc == sh_mepc)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t redirect_pc got %h expected %h",
             $time, $sampled(redirect_pc), $sampled(sh_mepc));
    end

  a_mtvec: assert property (@(posedge clk) disable iff (rst) mtvec == sh_mtvec)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t mtvec got %h expected %h",
             $time, $sampled(mtvec), $sampled(sh_mtvec));
    end

  a_mepc: assert property (@(posedge clk) disable iff (rst) mepc == sh_mepc)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t mepc got %h expected %h",
             $time, $sampled(mepc), $sampled(sh_mepc));
    end

  a_mie: assert property (@(posedge clk) disable iff (rst)
    mie == sh_mstatus[`MSTATUS_MIE_IDX])
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t mie got %b expected %b",
             $time, $sampled(mie), $sampled(sh_mstatus[`MSTATUS_MIE_IDX]));
    end

  a_ecall_next: assert property (@(posedge clk) disable iff (rst)
    is_ecall |=> (mepc == ecall_pc) && !mie)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t after ecall mepc got %h expected %h, mie got %b expected 0",
             $time, $sampled(mepc), $sampled(ecall_pc), $sampled(mie));
    end

  a_mret_next: assert property (@(posedge clk) disable iff (rst)
    is_mret |=> mie == stacked_mpie)
    else begin
      count_failure();
      $error("CHECK FAILED t=%0t after mret mie got %b expected %b",
             $time, $sampled(mie), $sampled(stacked_mpie));
    end

endmodule

// File: tb/exu_csr_tb.sv
`timescale 1ns/1ps
`include "csr_addr.svh"

module exu_csr_tb;

  localparam int xlen           = exu_pkg::xlen;
  localparam int seq_len        = 200;
  localparam int timeout_cycles = 2 * seq_len;

  localparam logic [31:0] inst_nop   = 32'h0000_0013;
  localparam logic [31:0] inst_ecall = 32'h0000_0073;
  localparam logic [31:0] inst_mret  = 32'h3020_0073;

  localparam logic [2:0] f3_rw  = 3'b001;
  localparam logic [2:0] f3_rs  = 3'b010;
  localparam logic [2:0] f3_rc  = 3'b011;
  localparam logic [2:0] f3_rwi = 3'b101;
  localparam logic [2:0] f3_rsi = 3'b110;
  localparam logic [2:0] f3_rci = 3'b111;

  logic            clk;
  logic            rst;
  logic            valid;
  logic [31:0]     inst;
  logic [xlen-1:0] pc;
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rd_data;
  logic            redirect;
  logic [xlen-1:0] redirect_pc;
  logic [xlen-1:0] mtvec;
  logic [xlen-1:0] mepc;
  logic            mie;

  integer          seed;
  int              cycle_count = 0;
  int              issued;
  logic [xlen-1:0] cur_pc;

  tb_clk_gen u_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  exu_csr_unit #(.XLEN(xlen)) uut (
    .clk         (clk),
    .rst         (rst),
    .valid       (valid),
    .inst        (inst),
    .pc          (pc),
    .rs1_data    (rs1_data),
    .rd_data     (rd_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .mtvec       (mtvec),
    .mepc        (mepc),
    .mie         (mie)
  );

  bind exu_csr_unit exu_csr_sva u_sva (
    .clk (clk), .rst (rst), .valid (valid), .inst (inst), .pc (pc),
    .rs1_data (rs1_data), .rd_data (rd_data), .redirect (redirect),
    .redirect_pc (redirect_pc), .mtvec (mtvec), .mepc (mepc), .mie (mie)
  );

  // rd is x1, the CSR ignores it.
  function automatic logic [31:0] csr_word(input logic [2:0] f3, input logic [11:0] addr,
                                           input logic [4:0] src);
    return {addr, src, f3, 5'd1, 7'b1110011};
  endfunction

  task automatic issue(input logic [31:0] word, input logic [xlen-1:0] rs1_val);
    @(negedge clk);
    valid    = 1'b1;
    inst     = word;
    pc       = cur_pc;
    rs1_data = rs1_val;
    cur_pc   = cur_pc + 32'd4;
    issued++;
  endtask

  task automatic present_idle(input logic [31:0] word, input logic [xlen-1:0] rs1_val);
    @(negedge clk);
    valid    = 1'b0;
    inst     = word;
    pc       = cur_pc;
    rs1_data = rs1_val;
  endtask

  task automatic csr_access(input logic [2:0] f3, input logic [11:0] addr,
                            input logic [4:0] src, input logic [xlen-1:0] rs1_val);
    issue(csr_word(f3, addr, src), rs1_val);
  endtask

  task automatic run_directed();
    csr_access(f3_rs, `CSR_MVENDORID, 5'd0, 32'h0);
    csr_access(f3_rs, `CSR_MARCHID, 5'd0, 32'h0);
    csr_access(f3_rw, `CSR_MVENDORID, 5'd2, 32'hffff_ffff);
    csr_access(f3_rsi, `CSR_MARCHID, 5'd31, 32'h0);
    csr_access(f3_rs, `CSR_MVENDORID, 5'd0, 32'h0);
    csr_access(f3_rs, `CSR_MARCHID, 5'd0, 32'h0);
    csr_access(f3_rw, `CSR_MTVEC, 5'd3, 32'h8000_0103);
    csr_access(f3_rs, `CSR_MTVEC, 5'd4, 32'h0000_0030);
    csr_access(f3_rc, `CSR_MTVEC, 5'd5, 32'h0000_0100);
    csr_access(f3_rwi, `CSR_MTVEC, 5'd17, 32'h0);
    csr_access(f3_rsi, `CSR_MTVEC, 5'd6, 32'h0);
    csr_access(f3_rci, `CSR_MTVEC, 5'd2, 32'h0);
    csr_access(f3_rw, `CSR_MTVEC, 5'd7, 32'h2000_0402);
    // zero source field with a busy rs1_data.
    csr_access(f3_rs, `CSR_MTVEC, 5'd0, 32'hffff_ffff);
    csr_access(f3_rc, `CSR_MTVEC, 5'd0, 32'hffff_ffff);
    csr_access(f3_rsi, `CSR_MTVEC, 5'd0, 32'hffff_ffff);
    csr_access(f3_rci, `CSR_MTVEC, 5'd0, 32'hffff_ffff);
    csr_access(f3_rsi, `CSR_MSTATUS, 5'd8, 32'h0); // mie on.
    csr_access(f3_rw, `CSR_MSTATUS, 5'd9, 32'h0000_0088);
    csr_access(f3_rc, `CSR_MSTATUS, 5'd10, 32'h0000_0080);
    csr_access(f3_rs, `CSR_MSTATUS, 5'd0, 32'h0);
    issue(inst_ecall, 32'h0);
    csr_access(f3_rs, `CSR_MCAUSE, 5'd0, 32'h0);
    csr_access(f3_rs, `CSR_MEPC, 5'd0, 32'h0);
    csr_access(f3_rs, `CSR_MSTATUS, 5'd0, 32'h0);
    issue(inst_mret, 32'h0);
    csr_access(f3_rs, `CSR_MSTATUS, 5'd0, 32'h0);
    csr_access(f3_rci, `CSR_MSTATUS, 5'd8, 32'h0);
    issue(inst_ecall, 32'h0);
    issue(inst_mret, 32'h0); // back to back trap and return.
    csr_access(f3_rw, `CSR_MEPC, 5'd11, 32'h0000_4000);
    issue(inst_mret, 32'h0);
    present_idle(inst_ecall, 32'h0);
    present_idle(inst_mret, 32'h0);
    present_idle(csr_word(f3_rw, `CSR_MTVEC, 5'd1), 32'hdead_beef);
    csr_access(f3_rs, `CSR_MTVEC, 5'd0, 32'h0);
    csr_access(f3_rw, 12'h7c0, 5'd12, 32'h1234_5678); // unmapped.
    csr_access(f3_rs, 12'h7c0, 5'd0, 32'h0);
  endtask

  task automatic pick_word(output logic [31:0] word);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [11:0] addr;
    logic [4:0]  src;
    r  = $random(seed);
    f3 = {r[6], (r[5:4] == 2'b00) ? 2'b01 : r[5:4]};
    case (r[9:7])
      3'd0, 3'd6: addr = `CSR_MSTATUS;
      3'd1, 3'd7: addr = `CSR_MTVEC;
      3'd2:       addr = `CSR_MEPC;
      3'd3:       addr = `CSR_MCAUSE;
      3'd4:       addr = `CSR_MVENDORID;
      default:    addr = `CSR_MARCHID;
    endcase
    src = (r[11:10] == 2'b00) ? 5'd0 : r[16:12]; // zero source about a quarter of the time.
    case (r[3:0])
      4'd0:    word = inst_ecall;
      4'd1:    word = inst_mret;
      default: word = csr_word(f3, addr, src);
    endcase
  endtask

  task automatic run_random();
    logic [31:0] word;
    logic [31:0] r;
    logic [31:0] rs1_val;
    while (issued < seq_len) begin
      r       = $random(seed);
      rs1_val = $random(seed);
      pick_word(word);
      if (r[1:0] == 2'b00)
        present_idle(word, rs1_val);
      else
        issue(word, rs1_val);
    end
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("Errors found");
      $fatal(1, "run did not finish within %0d cycles", timeout_cycles);
    end
  end

  always @(negedge clk) begin
    if (uut.u_sva.fail_count != 0) begin
      $display("Errors found");
      $fatal(1, "an assertion in the checker failed");
    end
  end

  initial begin
    valid    = 1'b0;
    inst     = inst_nop;
    pc       = '0;
    rs1_data = '0;
    seed     = 32'h4386ee33;
    cur_pc   = 32'h0000_1000;
    issued   = 0;
    wait (!rst);
    run_directed();
    run_random();
    present_idle(inst_nop, '0);
    repeat (2) @(negedge clk); // last state update settles.
    if (uut.u_sva.fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
source/exu_pkg.sv
source/csr_decode.sv
source/csr_exec.sv
source/csr_regfile.sv
source/exu_csr_unit.sv
tb/tb_clk_gen.sv
tb/exu_csr_sva.sv
tb/exu_csr_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the CSR unit testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
    -f build.f --top-module exu_csr_tb -o exu_csr_sim; then
  echo "verilator build failed"
  exit 1
fi

# keep running past the first assertion so the testbench reports it.
output=$(./obj_dir/exu_csr_sim +verilator+error+limit+100 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "No errors"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1
